// File: common/shadd_pkg.sv
package shadd_pkg;

    localparam int WORD_W = 64;
    localparam int N_OPS  = 6;

    // fixed left shift per operand
    localparam int SHIFT_0 = 0;
    localparam int SHIFT_1 = 1;
    localparam int SHIFT_2 = 2;
    localparam int SHIFT_3 = 4;
    localparam int SHIFT_4 = 8;
    localparam int SHIFT_5 = 16;

    localparam int SHIFT_AMT [N_OPS] = '{
        SHIFT_0,
        SHIFT_1,
        SHIFT_2,
        SHIFT_3,
        SHIFT_4,
        SHIFT_5
    };

    localparam int ADD_SPLITS = 1;
    localparam int ADD_LAT    = 1 << ADD_SPLITS; // adder cycles
    localparam int SHADD_LAT  = 2 + ADD_LAT;     // 6:3 + 3:2 + adder

    localparam int TAG_W  = 8;
    localparam int PEND_W = 4;

    typedef logic [WORD_W-1:0] word_t;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
    } op_meta_t;

endpackage : shadd_pkg

// File: rtl/delay_line.sv
module delay_line #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 1
) (
    input  logic     clk,
    input  logic     rst,
    input  payload_t in_i,
    output payload_t out_o
);

    payload_t pipe [DEPTH];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                pipe[i] <= '0;
            end
        end else begin
            pipe[0] <= in_i;
            for (int i = 1; i < DEPTH; i++) begin
                pipe[i] <= pipe[i-1]; // shift one stage
            end
        end
    end

    assign out_o = pipe[DEPTH-1];

endmodule : delay_line

// File: rtl/compress_6_3.sv
module compress_6_3
    import shadd_pkg::*;
#(
    parameter type meta_t = logic
) (
    input  logic  clk,
    input  logic  rst,
    input  word_t in0_i,
    input  word_t in1_i,
    input  word_t in2_i,
    input  word_t in3_i,
    input  word_t in4_i,
    input  word_t in5_i,
    output word_t sum_o,
    output word_t carry1_o,
    output word_t carry2_o,
    input  meta_t meta_i,
    output meta_t meta_o
);

    word_t s_n;
    word_t c1_n;
    word_t c2_n;

    // popcount of six bits per column, weights 1/2/4
    always_comb begin
        for (int i = 0; i < WORD_W; i++) begin
            {c2_n[i], c1_n[i], s_n[i]} = 3'(in0_i[i]) + 3'(in1_i[i]) + 3'(in2_i[i])
                                       + 3'(in3_i[i]) + 3'(in4_i[i]) + 3'(in5_i[i]);
        end
    end

    always_ff @(posedge clk) begin
        sum_o    <= s_n;
        carry1_o <= c1_n;
        carry2_o <= c2_n;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            meta_o <= '0;
        end else begin
            meta_o <= meta_i;
        end
    end

endmodule : compress_6_3

// File: rtl/compress_3_2.sv
module compress_3_2
    import shadd_pkg::*;
#(
    parameter type meta_t = logic
) (
    input  logic  clk,
    input  logic  rst,
    input  word_t in0_i,
    input  word_t in1_i,
    input  word_t in2_i,
    output word_t sum_o,
    output word_t carry_o,
    input  meta_t meta_i,
    output meta_t meta_o
);

    // one full adder per column
    always_ff @(posedge clk) begin
        sum_o   <= in0_i ^ in1_i ^ in2_i;
        carry_o <= (in0_i & in1_i) | (in0_i & in2_i) | (in1_i & in2_i); // majority
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            meta_o <= '0;
        end else begin
            meta_o <= meta_i;
        end
    end

endmodule : compress_3_2

// File: rtl/split_carry_adder.sv
module split_carry_adder
    import shadd_pkg::*;
#(
    parameter int  W      = WORD_W,
    parameter int  SPLITS = ADD_SPLITS,
    parameter type meta_t = logic
) (
    input  logic         clk,
    input  logic         rst,
    input  logic [W-1:0] in0_i,
    input  logic [W-1:0] in1_i,
    output logic [W-1:0] sum_o,
    input  meta_t        meta_i,
    output meta_t        meta_o
);

    if (SPLITS == 0) begin : g_leaf
        always_ff @(posedge clk) begin
            sum_o <= in0_i + in1_i;
        end

        always_ff @(posedge clk) begin
            if (rst) begin
                meta_o <= '0;
            end else begin
                meta_o <= meta_i;
            end
        end
    end else begin : g_split
        localparam int W_LO    = W / 2;
        localparam int W_HI    = W - W_LO;
        localparam int LAT_SUB = 1 << (SPLITS - 1);

        typedef struct packed {
            logic [W_HI-1:0] a;
            logic [W_HI-1:0] b;
        } hi_ops_t;

        typedef struct packed {
            meta_t           meta;
            logic [W_LO-1:0] lo;
        } hi_meta_t;

        logic [W_LO:0] lo_sum; // top bit is the carry into the high half
        hi_ops_t       hi_d;
        meta_t         meta_lo;
        logic [W_HI:0] hi_sum;
        hi_meta_t      hi_meta;

        split_carry_adder #(.W(W_LO + 1), .SPLITS(SPLITS - 1), .meta_t(meta_t)) lo_inst (
            .clk    (clk),
            .rst    (rst),
            .in0_i  ({1'b0, in0_i[W_LO-1:0]}),
            .in1_i  ({1'b0, in1_i[W_LO-1:0]}),
            .sum_o  (lo_sum),
            .meta_i (meta_i),
            .meta_o (meta_lo)
        );

        // high operands wait for the low carry
        delay_line #(.payload_t(hi_ops_t), .DEPTH(LAT_SUB)) hi_dly_inst (
            .clk   (clk),
            .rst   (rst),
            .in_i  ('{a: in0_i[W-1:W_LO], b: in1_i[W-1:W_LO]}),
            .out_o (hi_d)
        );

        // carry in via extra lsb, {a,1} + {b,c} ripples c into bit 1
        split_carry_adder #(.W(W_HI + 1), .SPLITS(SPLITS - 1), .meta_t(hi_meta_t)) hi_inst (
            .clk    (clk),
            .rst    (rst),
            .in0_i  ({hi_d.a, 1'b1}),
            .in1_i  ({hi_d.b, lo_sum[W_LO]}),
            .sum_o  (hi_sum),
            .meta_i ('{meta: meta_lo, lo: lo_sum[W_LO-1:0]}),
            .meta_o (hi_meta)
        );

        assign sum_o  = {hi_sum[W_HI:1], hi_meta.lo};
        assign meta_o = hi_meta.meta;
    end

endmodule : split_carry_adder

// File: rtl/shift_adder_6.sv
module shift_adder_6
    import shadd_pkg::*;
#(
    parameter type meta_t = logic
) (
    input  logic  clk,
    input  logic  rst,
    input  word_t op0_i,
    input  word_t op1_i,
    input  word_t op2_i,
    input  word_t op3_i,
    input  word_t op4_i,
    input  word_t op5_i,
    input  meta_t meta_i,
    output meta_t meta_o,
    output word_t sum_o
);

    word_t ops     [N_OPS];
    word_t shifted [N_OPS];

    word_t s63;
    word_t c1_63;
    word_t c2_63;
    meta_t meta_63;

    word_t s32;
    word_t c32;
    meta_t meta_32;

    assign ops = '{op0_i, op1_i, op2_i, op3_i, op4_i, op5_i};

    for (genvar k = 0; k < N_OPS; k++) begin : g_shift
        assign shifted[k] = ops[k] << SHIFT_AMT[k]; // bits above WORD_W drop
    end

    compress_6_3 #(.meta_t(meta_t)) c63_inst (
        .clk      (clk),
        .rst      (rst),
        .in0_i    (shifted[0]),
        .in1_i    (shifted[1]),
        .in2_i    (shifted[2]),
        .in3_i    (shifted[3]),
        .in4_i    (shifted[4]),
        .in5_i    (shifted[5]),
        .sum_o    (s63),
        .carry1_o (c1_63),
        .carry2_o (c2_63),
        .meta_i   (meta_i),
        .meta_o   (meta_63)
    );

    // carry words move up to their column weight
    compress_3_2 #(.meta_t(meta_t)) c32_inst (
        .clk     (clk),
        .rst     (rst),
        .in0_i   (s63),
        .in1_i   ({c1_63[WORD_W-2:0], 1'b0}),
        .in2_i   ({c2_63[WORD_W-3:0], 2'b00}),
        .sum_o   (s32),
        .carry_o (c32),
        .meta_i  (meta_63),
        .meta_o  (meta_32)
    );

    split_carry_adder #(.W(WORD_W), .SPLITS(ADD_SPLITS), .meta_t(meta_t)) add_inst (
        .clk    (clk),
        .rst    (rst),
        .in0_i  (s32),
        .in1_i  ({c32[WORD_W-2:0], 1'b0}),
        .sum_o  (sum_o),
        .meta_i (meta_32),
        .meta_o (meta_o)
    );

endmodule : shift_adder_6

// File: rtl/shadd_top.sv
module shadd_top
    import shadd_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              valid_i,
    input  logic [TAG_W-1:0]  tag_i,
    input  word_t             op0_i,
    input  word_t             op1_i,
    input  word_t             op2_i,
    input  word_t             op3_i,
    input  word_t             op4_i,
    input  word_t             op5_i,
    output logic              valid_o,
    output logic [TAG_W-1:0]  tag_o,
    output word_t             sum_o,
    output logic [PEND_W-1:0] pending_o
);

    op_meta_t          meta_in;
    op_meta_t          meta_out;
    logic [PEND_W-1:0] pending_q;

    assign meta_in = '{valid: valid_i, tag: tag_i};

    shift_adder_6 #(.meta_t(op_meta_t)) shadd_inst (
        .clk    (clk),
        .rst    (rst),
        .op0_i  (op0_i),
        .op1_i  (op1_i),
        .op2_i  (op2_i),
        .op3_i  (op3_i),
        .op4_i  (op4_i),
        .op5_i  (op5_i),
        .meta_i (meta_in),
        .meta_o (meta_out),
        .sum_o  (sum_o)
    );

    assign valid_o = meta_out.valid;
    assign tag_o   = meta_out.tag;

    // ops in flight, accept and retire together hold
    always_ff @(posedge clk) begin
        if (rst) begin
            pending_q <= '0;
        end else begin
            case ({valid_i, valid_o})
                2'b10:   pending_q <= pending_q + 1'b1;
                2'b01:   pending_q <= pending_q - 1'b1;
                default: pending_q <= pending_q;
            endcase
        end
    end

    assign pending_o = pending_q;

endmodule : shadd_top

// File: tests/shadd_assert.sv
module shadd_assert
    import shadd_pkg::*;
(
    input logic              clk,
    input logic              rst,
    input logic              valid_i,
    input logic              valid_o,
    input logic [PEND_W-1:0] pending_o
);

    timeunit 1ns;
    timeprecision 100ps;

    int assert_fails = 0;

    a_valid_lat: assert property (@(posedge clk) disable iff (rst)
        valid_o == $past(valid_i, SHADD_LAT))
        else begin
            assert_fails++;
            $error("valid_o does not follow valid_i by the pipeline latency");
        end

    a_pend_max: assert property (@(posedge clk) disable iff (rst) pending_o <= SHADD_LAT)
        else begin
            assert_fails++;
            $error("pending_o exceeds the pipeline depth");
        end

    // outputs quiet on the first cycle out of reset
    a_reset_out: assert property (@(posedge clk) $fell(rst) |-> !valid_o)
        else begin
            assert_fails++;
            $error("valid_o set right after reset");
        end

endmodule : shadd_assert

bind shadd_top shadd_assert assert_inst (
    .clk       (clk),
    .rst       (rst),
    .valid_i   (valid_i),
    .valid_o   (valid_o),
    .pending_o (pending_o)
);

// File: tests/shadd_tb.sv
module shadd_tb
    import shadd_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESULT_TIMEOUT = 20;
    localparam int DRAIN_TIMEOUT  = 60;

    logic              clk;
    logic              rst;
    logic              valid_d;
    logic [TAG_W-1:0]  tag_d;
    word_t             op_d [N_OPS];
    logic              valid_o;
    logic [TAG_W-1:0]  tag_o;
    word_t             sum_o;
    logic [PEND_W-1:0] pending_o;

    int               errors       = 0;
    int               checks       = 0;
    int               cycle_cnt    = 0;
    int               exp_pend     = 0;
    word_t            exp_sum_q [$];
    logic [TAG_W-1:0] exp_tag_q [$];
    int               acc_cyc_q [$];

    shadd_top shadd_top_inst (
        .clk       (clk),
        .rst       (rst),
        .valid_i   (valid_d),
        .tag_i     (tag_d),
        .op0_i     (op_d[0]),
        .op1_i     (op_d[1]),
        .op2_i     (op_d[2]),
        .op3_i     (op_d[3]),
        .op4_i     (op_d[4]),
        .op5_i     (op_d[5]),
        .valid_o   (valid_o),
        .tag_o     (tag_o),
        .sum_o     (sum_o),
        .pending_o (pending_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // shifted operands summed modulo 2^WORD_W
    function automatic word_t model_sum(input word_t ops [N_OPS]);
        word_t acc;
        acc = '0;
        for (int k = 0; k < N_OPS; k++) begin
            acc += ops[k] << SHIFT_AMT[k];
        end
        return acc;
    endfunction

    task automatic check(input word_t actual, input word_t expected, input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic abort(input string why);
        $display("%s", why);
        errors += 1 + shadd_top_inst.assert_inst.assert_fails;
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("Finished with errors");
        $finish;
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic send_op(input word_t ops [N_OPS], input logic [TAG_W-1:0] tag);
        op_d    = ops;
        tag_d   = tag;
        valid_d = 1'b1;
        step();
        valid_d = 1'b0;
    endtask

    task automatic idle(input int n);
        valid_d = 1'b0;
        repeat (n) step();
    endtask

    task automatic wait_result(output int lat);
        lat = 1; // send_op already crossed the accepting edge
        while (valid_o !== 1'b1) begin
            if (lat >= RESULT_TIMEOUT) abort("no result came out of the DUT in time");
            step();
            lat++;
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_sum_q.size() != 0) begin
            if (n >= DRAIN_TIMEOUT) abort("the pipeline did not drain in time");
            step();
            n++;
        end
    endtask

    // scoreboard and pending counter model
    always @(posedge clk) begin
        cycle_cnt++;
        if (rst) begin
            exp_pend = 0;
        end else begin
            check(pending_o, exp_pend, "pending_o");
            if (valid_o) begin
                if (exp_sum_q.size() == 0) begin
                    errors++;
                    $display("A result came out at %0t ns with nothing in flight", $time);
                end else begin
                    check(sum_o, exp_sum_q.pop_front(), "sum_o");
                    check(tag_o, exp_tag_q.pop_front(), "tag_o");
                    check(cycle_cnt - acc_cyc_q.pop_front(), SHADD_LAT, "result latency");
                end
            end
            if (valid_d) begin
                exp_sum_q.push_back(model_sum(op_d));
                exp_tag_q.push_back(tag_d);
                acc_cyc_q.push_back(cycle_cnt);
            end
            if (valid_d && !valid_o) exp_pend++;
            else if (!valid_d && valid_o) exp_pend--;
        end
    end

    task automatic after_reset();
        check(pending_o, 0, "pending_o after reset");
        check(valid_o, 0, "valid_o after reset");
    endtask

    task automatic single_op();
        word_t ops [N_OPS];
        int    lat;
        ops = '{64'd1, 64'd2, 64'd3, 64'd4, 64'd5, 64'd6};
        send_op(ops, 8'h11);
        wait_result(lat);
        check(lat, SHADD_LAT, "single op latency");
        check(sum_o, model_sum(ops), "single op sum");
        check(tag_o, 8'h11, "single op tag");
        wait_drain();
    endtask

    task automatic back_to_back_stream();
        word_t ops [N_OPS];
        int    max_pend;
        max_pend = 0;
        for (int i = 0; i < 20; i++) begin
            for (int k = 0; k < N_OPS; k++) begin
                ops[k] = {$urandom, $urandom};
            end
            send_op(ops, TAG_W'(8'h40 + i));
            if (pending_o > max_pend) max_pend = pending_o;
        end
        wait_drain();
        check(pending_o, 0, "pending_o after stream");
        check(max_pend, SHADD_LAT, "peak pending_o");
    endtask

    task automatic all_ones_wrap();
        word_t ops [N_OPS];
        int    lat;
        ops = '{default: '1}; // carries cross the adder halves
        send_op(ops, 8'hff);
        wait_result(lat);
        check(sum_o, model_sum(ops), "all ones sum");
        check(tag_o, 8'hff, "all ones tag");
        wait_drain();
    endtask

    task automatic gapped_ops();
        word_t ops [N_OPS];
        ops = '{64'h10, 64'h20, 64'h30, 64'h40, 64'h50, 64'h60};
        send_op(ops, 8'h81);
        check(pending_o, 1, "pending_o after first op");
        idle(2);
        send_op(ops, 8'h82);
        send_op(ops, 8'h83);
        check(pending_o, 2, "pending_o with accept and retire");
        idle(5);
        send_op(ops, 8'h84);
        wait_drain();
        check(pending_o, 0, "pending_o after drain");
    endtask

    initial begin
        void'($urandom(32'hee7039ae));
        rst     = 1'b1;
        valid_d = 1'b0;
        tag_d   = '0;
        for (int k = 0; k < N_OPS; k++) begin
            op_d[k] = '0;
        end
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        after_reset();
        single_op();
        back_to_back_stream();
        all_ones_wrap();
        gapped_ops();
        errors += shadd_top_inst.assert_inst.assert_fails;
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule : shadd_tb

// File: shadd.f
common/shadd_pkg.sv
rtl/delay_line.sv
rtl/compress_6_3.sv
rtl/compress_3_2.sv
rtl/split_carry_adder.sv
rtl/shift_adder_6.sv
rtl/shadd_top.sv
tests/shadd_assert.sv
tests/shadd_tb.sv
